//--- verilog/isaPkg.sv
package isaPkg;

  localparam int opWidth     = 5;
  localparam int regIdxWidth = 4;
  localparam int immWidth    = 19;
  localparam int spareWidth  = 15;

  typedef enum logic [opWidth-1:0] {
    opAdd  = 5'd3,
    opSub  = 5'd4,
    opAnd  = 5'd5,
    opOr   = 5'd6,
    opAddi = 5'd12,
    opMul  = 5'd15,
    opDiv  = 5'd16
  } opcodeT;

  typedef logic [regIdxWidth-1:0] regIdxT;

  // Three-register form: ra = rb op rc
  typedef struct packed {
    opcodeT                opcode;
    regIdxT                ra;
    regIdxT                rb;
    regIdxT                rc;
    logic [spareWidth-1:0] spare;
  } rFormT;

  // Immediate form: ra = rb + imm
  typedef struct packed {
    opcodeT              opcode;
    regIdxT              ra;
    regIdxT              rb;
    logic [immWidth-1:0] imm; // Zero-extended
  } iFormT;

  typedef union packed {
    rFormT rForm;
    iFormT iForm;
  } instrWordT;

  // Mul and div write LO/HI instead of ra
  function automatic logic isMulDiv(input opcodeT op);
    return (op == opMul) || (op == opDiv);
  endfunction

endpackage

//--- verilog/busPkg.sv
package busPkg;

  // Who drives the shared bus this step
  typedef enum logic [2:0] {
    srcNone  = 3'd0,
    srcReg   = 3'd1,
    srcImm   = 3'd2,
    srcZLow  = 3'd3,
    srcZHigh = 3'd4,
    srcHi    = 3'd5,
    srcLo    = 3'd6
  } busSrcT;

  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluPass = 3'd4,
    aluMul  = 3'd5
  } aluOpT;

  typedef enum logic [3:0] {
    stIdle, stT1, stT2, stT3, stT4, stT5, stDivWait, stResHold
  } stepT;

endpackage

//--- verilog/regFile.sv
`timescale 1ns/1ns
module regFile
  import isaPkg::*;
#(
  parameter int dataWidth = 32,
  parameter int numRegs   = 16
) (
  input  logic                 Clock,
  input  logic                 rstN,
  input  regIdxT               regRead,
  input  logic                 regWrite,
  input  regIdxT               writeIdx,
  input  logic [dataWidth-1:0] bus,
  output logic [dataWidth-1:0] readData
);

  logic [dataWidth-1:0] regs [numRegs];

  // Synchronous read, so the index is presented one step ahead of its bus slot
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
      readData <= '0;
    end else begin
      if (regWrite && (writeIdx != '0)) begin // R0 stays zero
        regs[writeIdx] <= bus;
      end
      readData <= regs[regRead];
    end
  end

endmodule

//--- verilog/aluUnit.sv
`timescale 1ns/1ns
module aluUnit
  import busPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  aluOpT                  aluOp,
  input  logic [dataWidth-1:0]   yValue,
  input  logic [dataWidth-1:0]   bus,
  output logic [2*dataWidth-1:0] zValue
);

  logic [2*dataWidth-1:0] product;

  // Unsigned full-width product in one cycle
  assign product = {{dataWidth{1'b0}}, yValue} * {{dataWidth{1'b0}}, bus};

  always_comb begin
    zValue = '0; // High half is zero unless multiplying
    unique case (aluOp)
      aluAdd: begin
        zValue[dataWidth-1:0] = yValue + bus;
      end
      aluSub: begin
        zValue[dataWidth-1:0] = yValue - bus; // Wraps on underflow
      end
      aluAnd: begin
        zValue[dataWidth-1:0] = yValue & bus;
      end
      aluOr: begin
        zValue[dataWidth-1:0] = yValue | bus;
      end
      aluMul: begin
        zValue = product;
      end
      default: begin
        zValue[dataWidth-1:0] = bus; // Pass
      end
    endcase
  end

endmodule

//--- verilog/divider.sv
`timescale 1ns/1ns
module divider #(
  parameter int dataWidth = 32
) (
  input  logic                 Clock,
  input  logic                 rstN,
  input  logic                 divStart,
  input  logic [dataWidth-1:0] dividend,
  input  logic [dataWidth-1:0] divisor,
  output logic [dataWidth-1:0] quotient,
  output logic [dataWidth-1:0] remainder,
  output logic                 divDone
);

  localparam int cntWidth = $clog2(dataWidth);
  localparam logic [cntWidth-1:0] lastStep = cntWidth'(dataWidth - 1);

  logic                 busy;
  logic [cntWidth-1:0]  stepCount;
  logic [dataWidth-1:0] remAcc;
  logic [dataWidth-1:0] quoAcc;
  logic [dataWidth-1:0] divisorReg;
  logic [dataWidth:0]   shifted;
  logic [dataWidth:0]   trial;

  // Bring the next dividend bit into the partial remainder and try a subtract
  assign shifted = {remAcc, quoAcc[dataWidth-1]};
  assign trial   = shifted - {1'b0, divisorReg};

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      busy      <= 1'b0;
      stepCount <= '0;
      divDone   <= 1'b0;
    end else begin
      divDone <= 1'b0;
      if (busy) begin
        stepCount <= stepCount + 1'b1;
        if (stepCount == lastStep) begin
          busy    <= 1'b0;
          divDone <= 1'b1;
        end
      end else if (divStart) begin // Start is ignored while busy
        busy      <= 1'b1;
        stepCount <= '0;
      end
    end
  end

  // A zero divisor never borrows, so quotient ends all ones and remainder is the dividend
  always_ff @(posedge Clock) begin
    if (!busy && divStart) begin
      remAcc     <= '0;
      quoAcc     <= dividend;
      divisorReg <= divisor;
    end else if (busy) begin
      if (trial[dataWidth]) begin // Borrow, restore
        remAcc <= shifted[dataWidth-1:0];
        quoAcc <= {quoAcc[dataWidth-2:0], 1'b0};
      end else begin
        remAcc <= trial[dataWidth-1:0];
        quoAcc <= {quoAcc[dataWidth-2:0], 1'b1};
      end
    end
  end

  assign quotient  = quoAcc;
  assign remainder = remAcc;

endmodule

//--- verilog/busRegisters.sv
`timescale 1ns/1ns
module busRegisters
  import isaPkg::*;
  import busPkg::*;
#(
  parameter int dataWidth = 32
) (
  input  logic                   Clock,
  input  logic                   rstN,
  input  busSrcT                 busSrc,
  input  logic                   irLoad,
  input  logic                   yLoad,
  input  logic                   zLoad,
  input  logic                   hiLoad,
  input  logic                   loLoad,
  input  instrWordT              instrData,
  input  logic [dataWidth-1:0]   readData,
  input  logic [2*dataWidth-1:0] zValue,
  input  logic [dataWidth-1:0]   quotient,
  input  logic [dataWidth-1:0]   remainder,
  output logic [dataWidth-1:0]   bus,
  output instrWordT              instrWord,
  output logic [dataWidth-1:0]   yValue,
  output logic [2*dataWidth-1:0] zWord,
  output logic [dataWidth-1:0]   resValue,
  output logic [dataWidth-1:0]   resHi
);

  logic [dataWidth-1:0] hiReg;
  logic [dataWidth-1:0] loReg;

  always_comb begin
    unique case (busSrc)
      srcReg:   bus = readData;
      srcImm:   bus = {{(dataWidth-immWidth){1'b0}}, instrWord.iForm.imm};
      srcZLow:  bus = zWord[dataWidth-1:0];
      srcZHigh: bus = zWord[2*dataWidth-1:dataWidth];
      srcHi:    bus = hiReg;
      srcLo:    bus = loReg;
      default:  bus = '0; // Nobody drives
    endcase
  end

  always_ff @(posedge Clock) begin
    if (irLoad) instrWord <= instrData; // Taken on the accepting edge
    if (yLoad) yValue <= bus;
    if (zLoad) begin
      // Idle bus on a Z load means the divider is handing over its result
      zWord <= (busSrc == srcNone) ? {remainder, quotient} : zValue;
    end
  end

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      hiReg    <= '0;
      loReg    <= '0;
      resValue <= '0;
    end else begin
      if (hiLoad) hiReg <= bus;
      if (loLoad) loReg <= bus;
      if (busSrc == srcZLow) resValue <= bus; // Same word that goes to ra or LO
    end
  end

  assign resHi = hiReg;

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/1ns
module sequencer
  import isaPkg::*;
  import busPkg::*;
(
  input  logic      Clock,
  input  logic      rstN,
  input  logic      instrValid,
  output logic      instrReady,
  output logic      resValid,
  input  logic      resReady,
  output regIdxT    resDest,
  input  instrWordT instrWord,
  output busSrcT    busSrc,
  output aluOpT     aluOp,
  output regIdxT    regRead,
  output logic      regWrite,
  output logic      irLoad,
  output logic      yLoad,
  output logic      zLoad,
  output logic      hiLoad,
  output logic      loLoad,
  output logic      divStart,
  input  logic      divDone
);

  stepT   step;
  stepT   stepNext;
  opcodeT opcode;
  logic   isImm;
  logic   isDiv;
  logic   wideResult;
  aluOpT  decodedOp;

  assign opcode     = instrWord.rForm.opcode;
  assign isImm      = (instrWord.iForm.opcode == opAddi);
  assign isDiv      = (opcode == opDiv);
  assign wideResult = isMulDiv(opcode);
  assign resDest    = instrWord.rForm.ra; // IR holds until the next accept
  assign instrReady = (step == stIdle);

  always_comb begin
    unique case (opcode)
      opAdd, opAddi: decodedOp = aluAdd;
      opSub:         decodedOp = aluSub;
      opAnd:         decodedOp = aluAnd;
      opOr:          decodedOp = aluOr;
      opMul:         decodedOp = aluMul;
      default:       decodedOp = aluPass;
    endcase
  end

  // Step outputs and next step
  always_comb begin
    stepNext = step;
    busSrc   = srcNone;
    aluOp    = aluPass;
    regRead  = instrWord.rForm.rb;
    regWrite = 1'b0;
    irLoad   = 1'b0;
    yLoad    = 1'b0;
    zLoad    = 1'b0;
    hiLoad   = 1'b0;
    loLoad   = 1'b0;
    divStart = 1'b0;
    unique case (step)
      stIdle: begin
        irLoad = instrValid;
        if (instrValid) stepNext = stT1;
      end
      stT1: stepNext = stT2; // rb read address goes out
      stT2: begin
        busSrc   = srcReg; // rb into Y
        yLoad    = 1'b1;
        regRead  = instrWord.rForm.rc;
        stepNext = stT3;
      end
      stT3: begin
        if (isDiv) begin
          busSrc   = srcReg; // rc is the divisor
          divStart = 1'b1;
          stepNext = stDivWait;
        end else begin
          busSrc   = isImm ? srcImm : srcReg;
          aluOp    = decodedOp;
          zLoad    = 1'b1;
          stepNext = stT4;
        end
      end
      stDivWait: begin
        zLoad = divDone;
        if (divDone) stepNext = stT4;
      end
      stT4: begin
        busSrc   = srcZLow;
        loLoad   = wideResult;
        regWrite = !wideResult;
        stepNext = wideResult ? stT5 : stResHold;
      end
      stT5: begin
        busSrc   = srcZHigh;
        hiLoad   = 1'b1;
        stepNext = stResHold;
      end
      default: begin
        if (!resValid || resReady) stepNext = stIdle;
      end
    endcase
  end

  // Reset parks in result hold with no result, which drops to idle next cycle
  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      step     <= stResHold;
      resValid <= 1'b0;
    end else begin
      step     <= stepNext;
      resValid <= (stepNext == stResHold);
    end
  end

endmodule

//--- verilog/miniDatapath.sv
`timescale 1ns/1ns
module miniDatapath
  import isaPkg::*;
  import busPkg::*;
#(
  parameter int dataWidth = 32,
  parameter int numRegs   = 16
) (
  input  logic                 Clock,
  input  logic                 rstN,
  input  logic                 instrValid,
  input  logic [31:0]          instrData,
  output logic                 instrReady,
  output logic                 resValid,
  output logic [3:0]           resDest,
  output logic [dataWidth-1:0] resValue,
  output logic [dataWidth-1:0] resHi,
  input  logic                 resReady
);

  busSrcT                 busSrc;
  aluOpT                  aluOp;
  regIdxT                 regRead;
  instrWordT              instrWord;
  logic                   regWrite;
  logic                   irLoad;
  logic                   yLoad;
  logic                   zLoad;
  logic                   hiLoad;
  logic                   loLoad;
  logic                   divStart;
  logic                   divDone;
  logic [dataWidth-1:0]   bus;
  logic [dataWidth-1:0]   readData;
  logic [dataWidth-1:0]   yValue;
  logic [dataWidth-1:0]   quotient;
  logic [dataWidth-1:0]   remainder;
  logic [2*dataWidth-1:0] zValue;

  sequencer uSeq (
    .Clock, .rstN, .instrValid, .instrReady, .resValid, .resReady, .resDest,
    .instrWord, .busSrc, .aluOp, .regRead, .regWrite, .irLoad, .yLoad, .zLoad,
    .hiLoad, .loLoad, .divStart, .divDone
  );

  regFile #(.dataWidth(dataWidth), .numRegs(numRegs)) uRegs (
    .Clock, .rstN, .regRead, .regWrite, .writeIdx(resDest), .bus, .readData
  );

  aluUnit #(.dataWidth(dataWidth)) uAlu (.aluOp, .yValue, .bus, .zValue);

  divider #(.dataWidth(dataWidth)) uDiv (
    .Clock, .rstN, .divStart, .dividend(yValue), .divisor(bus), .quotient,
    .remainder, .divDone
  );

  busRegisters #(.dataWidth(dataWidth)) uBusRegs (
    .Clock, .rstN, .busSrc, .irLoad, .yLoad, .zLoad, .hiLoad, .loLoad, .instrData,
    .readData, .zValue, .quotient, .remainder, .bus, .instrWord, .yValue,
    .zWord(), .resValue, .resHi
  );

endmodule

//--- bench/datapathTb_assert.sv
`timescale 1ns/1ns
module datapathTb_assert (
  input logic        Clock,
  input logic        rstN,
  input logic        instrValid,
  input logic        instrReady,
  input logic [31:0] instrData,
  input logic        resValid,
  input logic        resReady,
  input logic [3:0]  resDest,
  input logic [31:0] resValue,
  input logic [31:0] resHi,
  input logic        divStart,
  input logic        divDone
);

  int failCount = 0; // Polled by the testbench checker

  // Source must hold the word until it is taken
  instrHeld: assert property (@(posedge Clock) disable iff (!rstN)
    instrValid && !instrReady |=> instrValid && $stable(instrData))
    else begin
      failCount++;
      $error("Instruction word changed or dropped before ready");
    end

  resultHeld: assert property (@(posedge Clock) disable iff (!rstN)
    resValid && !resReady |=>
      resValid && $stable(resDest) && $stable(resValue) && $stable(resHi))
    else begin
      failCount++;
      $error("Result changed or dropped under back-pressure");
    end

  divideEnds: assert property (@(posedge Clock) disable iff (!rstN)
    divStart |-> ##[1:33] divDone)
    else begin
      failCount++;
      $error("Divider did not finish within 33 cycles of start");
    end

endmodule

bind miniDatapath datapathTb_assert checks (.*);

//--- bench/datapathTb.sv
`timescale 1ns/1ns
module datapathTb
  import isaPkg::*;
;

  localparam int clkPeriod  = 20;
  localparam int numInstr   = 200;
  localparam int patternLen = 256;

  logic        Clock = 1'b0;
  logic        rstN;
  logic        instrValid;
  logic [31:0] instrData;
  logic        instrReady;
  logic        resValid;
  logic [3:0]  resDest;
  logic [31:0] resValue;
  logic [31:0] resHi;
  logic        resReady;

  int          seed;
  int          cycleCount = 0;
  int          resultCount = 0;
  logic        holding = 1'b0; // Current result already seen rising
  logic [31:0] instrList [numInstr];
  int          gapCycles [numInstr];
  logic        readyPattern [patternLen];
  opcodeT      opChoices [7] = '{opAdd, opSub, opAnd, opOr, opMul, opDiv, opAddi};

  // Reference model state
  logic [31:0] modelRegs [16];
  logic [31:0] modelHi;

  // Expected results in instruction order
  regIdxT      expDest [$];
  logic [31:0] expValue [$];
  logic [31:0] expHi [$];
  string       expName [$];
  int          expAccept [$];
  int          expLatency [$]; // Zero means not fixed (div)

  miniDatapath #(.dataWidth(32), .numRegs(16)) dut (
    .Clock(Clock), .rstN(rstN), .instrValid(instrValid), .instrData(instrData),
    .instrReady(instrReady), .resValid(resValid), .resDest(resDest),
    .resValue(resValue), .resHi(resHi), .resReady(resReady)
  );

  always #(clkPeriod / 2) Clock = ~Clock;

  always @(posedge Clock) cycleCount <= cycleCount + 1;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic checkField(input string testName, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      abortRun($sformatf("MISMATCH %s %s: expected %h actual %h",
                         testName, field, expected, actual));
    end
  endtask

  function automatic logic [31:0] encodeR(input opcodeT op, input regIdxT ra,
                                          input regIdxT rb, input regIdxT rc);
    instrWordT w;
    w.rForm.opcode = op;
    w.rForm.ra     = ra;
    w.rForm.rb     = rb;
    w.rForm.rc     = rc;
    w.rForm.spare  = '0;
    return w;
  endfunction

  function automatic logic [31:0] encodeI(input regIdxT ra, input regIdxT rb,
                                          input logic [18:0] imm);
    instrWordT w;
    w.iForm.opcode = opAddi;
    w.iForm.ra     = ra;
    w.iForm.rb     = rb;
    w.iForm.imm    = imm;
    return w;
  endfunction

  function automatic string opText(input opcodeT op);
    case (op)
      opAdd:   return "add";
      opSub:   return "sub";
      opAnd:   return "and";
      opOr:    return "or";
      opMul:   return "mul";
      opAddi:  return "addi";
      default: return "div";
    endcase
  endfunction

  // Expected dest, LO/result and HI for one instruction; updates the model
  function automatic void predictResult(input instrWordT w, output regIdxT dest,
                                        output logic [31:0] value, output logic [31:0] hi);
    logic [31:0] b;
    logic [31:0] c;
    logic [63:0] prod;
    b    = modelRegs[w.rForm.rb];
    c    = modelRegs[w.rForm.rc];
    dest = w.rForm.ra;
    hi   = modelHi;
    case (w.rForm.opcode)
      opAdd:  value = b + c;
      opSub:  value = b - c; // Wraps modulo 2^32
      opAnd:  value = b & c;
      opOr:   value = b | c;
      opAddi: value = b + {13'b0, w.iForm.imm};
      opMul: begin
        prod  = {32'b0, b} * {32'b0, c};
        value = prod[31:0];
        hi    = prod[63:32];
      end
      default: begin
        value = (c == 0) ? 32'hffff_ffff : b / c;
        hi    = (c == 0) ? b : b % c;
      end
    endcase
    if (w.rForm.opcode == opMul || w.rForm.opcode == opDiv) begin
      modelHi = hi;
    end else if (dest != 0) begin
      modelRegs[dest] = value; // R0 is never written
    end
  endfunction

  initial begin : mainFlow
    logic [31:0] rnd;
    int          pick;
    instrWordT   w;
    regIdxT      dest;
    logic [31:0] value;
    logic [31:0] hi;
    opcodeT      op;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instrData  = '0;
    resReady   = 1'b0;
    seed       = 29748;
    modelHi    = '0;
    for (int r = 0; r < 16; r++) modelRegs[r] = '0;
    for (int i = 0; i < patternLen; i++) begin
      readyPattern[i] = ($unsigned($random(seed)) % 3) != 0; // Stall about a third
    end
    // Load every register from R0, then a few directed corner cases
    for (int r = 1; r < 16; r++) begin
      rnd = $random(seed);
      instrList[r - 1] = encodeI(regIdxT'(r), 4'd0, rnd[18:0]);
    end
    rnd = $random(seed);
    instrList[15] = encodeI(4'd0, 4'd3, rnd[18:0]); // Write to R0 is dropped
    instrList[16] = encodeR(opSub, 4'd1, 4'd0, 4'd2); // Negative wrap
    instrList[17] = encodeR(opMul, 4'd9, 4'd1, 4'd1); // Large product
    instrList[18] = encodeR(opDiv, 4'd4, 4'd5, 4'd0); // Zero divisor
    instrList[19] = encodeR(opDiv, 4'd4, 4'd1, 4'd6);
    for (int i = 20; i < numInstr; i++) begin
      pick = $unsigned($random(seed)) % 7;
      rnd  = $random(seed);
      if (opChoices[pick] == opAddi) instrList[i] = encodeI(rnd[3:0], rnd[7:4], rnd[30:12]);
      else instrList[i] = encodeR(opChoices[pick], rnd[3:0], rnd[7:4], rnd[11:8]);
    end
    for (int i = 0; i < numInstr; i++) gapCycles[i] = $unsigned($random(seed)) % 9;

    repeat (4) @(negedge Clock);
    rstN = 1'b1;

    for (int i = 0; i < numInstr; i++) begin
      repeat (gapCycles[i]) begin
        instrValid = 1'b0;
        instrData  = $random(seed); // Junk while not valid
        @(negedge Clock);
      end
      instrValid = 1'b1;
      instrData  = instrList[i];
      while (!instrReady) @(negedge Clock);
      // Ready seen here, so the word transfers on the next rising edge
      w  = instrList[i];
      op = w.rForm.opcode;
      predictResult(w, dest, value, hi);
      expDest.push_back(dest);
      expValue.push_back(value);
      expHi.push_back(hi);
      expName.push_back($sformatf("%s #%0d", opText(op), i));
      expAccept.push_back(cycleCount + 1);
      expLatency.push_back(op == opMul ? 5 : (op == opDiv ? 0 : 4));
      @(negedge Clock);
    end
    instrValid = 1'b0;

    wait (resultCount == numInstr);
    repeat (5) @(negedge Clock); // Catch any extra result
    if (!resValid && dut.checks.failCount == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abortRun("Extra result or protocol error after the last instruction");
    end
  end

  // Compares each result on falling edges where outputs are settled
  always @(negedge Clock) begin : resultChecker
    int latency;
    if (rstN) begin
      resReady = readyPattern[cycleCount % patternLen];
      assert (dut.checks.failCount == 0) else abortRun("A bound protocol assertion fired");
      if (resValid) begin
        assert (expDest.size() > 0) else abortRun("Result came out with no instruction pending");
        if (!holding) begin
          holding = 1'b1;
          latency = cycleCount - expAccept[0];
          if (expLatency[0] != 0) begin
            assert (latency == expLatency[0]) else begin
              abortRun($sformatf("MISMATCH %s latency: expected %0d actual %0d",
                                 expName[0], expLatency[0], latency));
            end
          end
        end
        if (resReady) begin // Transfer on the next rising edge
          checkField(expName[0], "resDest", {28'b0, expDest[0]}, {28'b0, resDest});
          checkField(expName[0], "resValue", expValue[0], resValue);
          checkField(expName[0], "resHi", expHi[0], resHi);
          void'(expDest.pop_front());
          void'(expValue.pop_front());
          void'(expHi.pop_front());
          void'(expName.pop_front());
          void'(expAccept.pop_front());
          void'(expLatency.pop_front());
          holding = 1'b0;
          resultCount++;
        end
      end
    end
  end

  initial begin : watchdog
    #(numInstr * 40 * clkPeriod);
    abortRun("Timeout: not all results arrived in time");
  end

endmodule

//--- project.f
verilog/isaPkg.sv
verilog/busPkg.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/divider.sv
verilog/busRegisters.sv
verilog/sequencer.sv
verilog/miniDatapath.sv
bench/datapathTb_assert.sv
bench/datapathTb.sv

//--- Bender.yml
package:
  name: minidatapath

sources:
  - verilog/isaPkg.sv
  - verilog/busPkg.sv
  - verilog/regFile.sv
  - verilog/aluUnit.sv
  - verilog/divider.sv
  - verilog/busRegisters.sv
  - verilog/sequencer.sv
  - verilog/miniDatapath.sv
  - target: simulation
    files:
      - bench/datapathTb_assert.sv
      - bench/datapathTb.sv
